//--- Makefile
TOOL      := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_hazard_unit
FILELIST  := vlog.f
RUN_FLAGS := +verilator+error+limit+1000
LOG       := sim.log
PASS_MSG  := Regression passed
FAIL_MSG  := Regression failed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- dependency_check.sv
`timescale 1ns/10ps
`default_nettype none

`include "hazard_settings.svh"

module dependency_check (
    input  hazard_pkg::id_regs_t    id_regs,            // operands of the decode stage
    input  hazard_pkg::stage_dest_t ex_dest,            // instruction in ex
    input  hazard_pkg::stage_dest_t mem_dest,           // instruction in mem
    input  logic [`ISA_WIDTH-1:0]   pc,                 // current fetch address
    output logic                    data_hazard,        // decode has to wait
    output logic                    fallthrough         // fetch reached the last word
);

    logic src1_valid;                                   // x0 is hardwired, never a dependency
    logic src2_valid;
    logic store_valid;
    logic ex_match;
    logic mem_match;

    assign src1_valid  = (id_regs.src1_idx != '0);
    assign src2_valid  = (id_regs.src2_idx != '0);
    assign store_valid = id_regs.store & (id_regs.dest_idx != '0);   // store data comes from dest

    // result still in ex, not forwardable to a branch or after a load
    assign ex_match =
        (ex_dest.reg_write &
            ((src1_valid & (id_regs.src1_idx == ex_dest.dest_idx)) |
             (src2_valid & (id_regs.src2_idx == ex_dest.dest_idx)))) |
        (store_valid & (id_regs.dest_idx == ex_dest.dest_idx));      // stored value is the ex result

    // result in mem only matters for branches resolved in id
    assign mem_match =
        mem_dest.reg_write &
            ((src1_valid & (id_regs.src1_idx == mem_dest.dest_idx)) |
             (src2_valid & (id_regs.src2_idx == mem_dest.dest_idx)));

    assign data_hazard = (id_regs.branch & (ex_match | mem_match)) | // branch needs operands now
                         (ex_dest.mem_read & ex_match);              // load-use, one bubble

    assign fallthrough = (pc == `PC_MAX_VALUE);         // next fetch would leave the program

endmodule

`default_nettype wire

//--- hazard_pkg.sv
`default_nettype none

`include "hazard_settings.svh"

package hazard_pkg;

    // command to one stage register
    typedef enum logic [1:0] {
        HAZD_CTL_NORMAL = 2'b00,                        // latch the next instruction
        HAZD_CTL_RETRY  = 2'b01,                        // keep the current content
        HAZD_CTL_NO_OP  = 2'b10                         // load a bubble
    } hazd_ctl_t;

    // issue shown on the status display
    typedef enum logic [2:0] {
        ISSUE_NONE        = 3'd0,
        ISSUE_DATA        = 3'd1,                       // data hazard stall
        ISSUE_PAUSE       = 3'd2,                       // user pause, pipeline drained
        ISSUE_FALLTHROUGH = 3'd3,                       // pc ran past the program
        ISSUE_UART        = 3'd4,                       // program rewrite in progress
        ISSUE_KEYPAD      = 3'd5                        // waiting for keypad entry
    } issue_t;

    // operands of the instruction in decode
    typedef struct packed {
        logic [`REG_FILE_ADDR_WIDTH-1:0] src1_idx;      // first source register
        logic [`REG_FILE_ADDR_WIDTH-1:0] src2_idx;      // second source register
        logic [`REG_FILE_ADDR_WIDTH-1:0] dest_idx;      // destination, or store data source
        logic                            branch;        // branch compares in id
        logic                            store;         // store instruction
    } id_regs_t;

    // what an in-flight instruction will write back
    typedef struct packed {
        logic                            reg_write;     // writes the register file
        logic                            mem_read;      // load, data ready after mem
        logic [`REG_FILE_ADDR_WIDTH-1:0] dest_idx;
    } stage_dest_t;

    // one control per stage register
    typedef struct packed {
        hazd_ctl_t if_ctl;
        hazd_ctl_t id_ctl;
        hazd_ctl_t ex_ctl;
        hazd_ctl_t mem_ctl;
        hazd_ctl_t wb_ctl;
    } stage_ctl_t;

endpackage

`default_nettype wire

//--- hazard_settings.svh
`ifndef HAZARD_SETTINGS_SVH
`define HAZARD_SETTINGS_SVH

// sizes shared by the hazard unit and its package

`define REG_FILE_ADDR_WIDTH 5           // register index, 32 entry file
`define ISA_WIDTH           32          // pc width

// last word address of instruction memory
// fetching past it means the program fell through
`define PC_MAX_VALUE        32'h0000_3ffc

`define STAGE_CNT           5           // if, id, ex, mem, wb
`define STAGE_CNT_WIDTH     3           // gap counter, counts up to STAGE_CNT

`endif

//--- hazard_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "hazard_settings.svh"

module hazard_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  hazard_pkg::id_regs_t    id_regs,            // decode operands
    input  hazard_pkg::stage_dest_t ex_dest,            // from id_ex register
    input  hazard_pkg::stage_dest_t mem_dest,           // from ex_mem register
    input  logic [`ISA_WIDTH-1:0]   pc,                 // from instruction memory
    input  logic                    cpu_pause,          // user pause switch
    input  logic                    uart_write_enable,  // uart rewrite active
    input  logic                    uart_complete,      // uart rewrite done
    input  logic                    input_enable,       // data memory asks for keypad input
    input  logic                    input_complete,     // keypad entry done
    output hazard_pkg::stage_ctl_t  stage_ctl,          // to all five stage registers
    output hazard_pkg::issue_t      issue_type,         // to the vga status display
    output logic                    uart_disable,       // to instruction and data memory
    output logic                    ignore_pause,       // to the input unit
    output logic                    pc_reset,           // to instruction memory
    output logic                    tube_enable         // to the seven segment unit
);

    import hazard_pkg::*;

    logic       data_hazard;
    logic       fallthrough;
    logic       keypad_hold;
    stage_ctl_t next_ctl;
    issue_t     next_issue;

    dependency_check i_dependency_check (
        .id_regs     (id_regs),
        .ex_dest     (ex_dest),
        .mem_dest    (mem_dest),
        .pc          (pc),
        .data_hazard (data_hazard),
        .fallthrough (fallthrough)
    );

    issue_sequencer i_issue_sequencer (
        .clk               (clk),
        .rst_n             (rst_n),
        .data_hazard       (data_hazard),
        .fallthrough       (fallthrough),
        .cpu_pause         (cpu_pause),
        .uart_write_enable (uart_write_enable),
        .uart_complete     (uart_complete),
        .keypad_hold       (keypad_hold),
        .next_ctl          (next_ctl),
        .next_issue        (next_issue),
        .uart_disable      (uart_disable),
        .ignore_pause      (ignore_pause),
        .pc_reset          (pc_reset)
    );

    keypad_freeze i_keypad_freeze (
        .clk            (clk),
        .rst_n          (rst_n),
        .next_ctl       (next_ctl),
        .next_issue     (next_issue),
        .input_enable   (input_enable),
        .input_complete (input_complete),
        .stage_ctl      (stage_ctl),
        .issue_type     (issue_type),
        .tube_enable    (tube_enable),
        .keypad_hold    (keypad_hold)
    );

endmodule

`default_nettype wire

//--- hazard_unit_asserts.sv
`timescale 1ns/10ps
`default_nettype none

`include "hazard_settings.svh"

module hazard_unit_asserts (
    input logic                    clk,
    input logic                    rst_n,
    input hazard_pkg::id_regs_t    id_regs,
    input hazard_pkg::stage_dest_t ex_dest,
    input hazard_pkg::stage_dest_t mem_dest,
    input logic [`ISA_WIDTH-1:0]   pc,
    input logic                    cpu_pause,
    input logic                    uart_write_enable,
    input logic                    uart_complete,
    input logic                    input_enable,
    input logic                    input_complete,
    input hazard_pkg::stage_ctl_t  stage_ctl,
    input hazard_pkg::issue_t      issue_type,
    input logic                    uart_disable,
    input logic                    ignore_pause,
    input logic                    pc_reset,
    input logic                    tube_enable
);

    import hazard_pkg::*;

    localparam stage_ctl_t ALL_NORMAL = '{default: HAZD_CTL_NORMAL};
    localparam stage_ctl_t ALL_NO_OP  = '{default: HAZD_CTL_NO_OP};

    logic       run_q;                                  // past the idle cycle
    logic       free;                                   // no keypad freeze involved
    logic       dep;
    logic       at_max;
    logic       drain;
    stage_ctl_t saved_ctl;                              // controls seen when the freeze began
    issue_t     saved_issue;
    int         n_reset = 0;
    int         n_stall = 0;
    int         n_no_stall = 0;
    int         n_drain = 0;
    int         n_resume = 0;
    int         n_uart_start = 0;
    int         n_uart_done = 0;
    int         n_pulse = 0;
    int         n_freeze = 0;
    int         n_restore = 0;
    int         fail_cnt;                               // read by the testbench

    // operand depends on a result that the stage has yet to write
    function automatic logic reads_from(
        logic [`REG_FILE_ADDR_WIDTH-1:0] src,
        stage_dest_t                     dst
    );
        return dst.reg_write && (src != '0) && (src == dst.dest_idx);
    endfunction

    function automatic logic stall_rule(id_regs_t id, stage_dest_t ex, stage_dest_t mem);
        logic ex_hit;
        logic mem_hit;
        ex_hit  = reads_from(id.src1_idx, ex) || reads_from(id.src2_idx, ex)
                  || (id.store && (id.dest_idx != '0) && (id.dest_idx == ex.dest_idx));
        mem_hit = reads_from(id.src1_idx, mem) || reads_from(id.src2_idx, mem);
        return (id.branch && (ex_hit || mem_hit)) || (ex.mem_read && ex_hit);
    endfunction

    assign free     = !tube_enable && !input_enable;
    assign dep      = stall_rule(id_regs, ex_dest, mem_dest);
    assign at_max   = (pc == `PC_MAX_VALUE);
    assign drain    = cpu_pause || at_max;
    assign fail_cnt = n_reset + n_stall + n_no_stall + n_drain + n_resume
                      + n_uart_start + n_uart_done + n_pulse + n_freeze + n_restore;

    always_ff @(posedge clk) begin
        run_q <= rst_n;                                 // low through the idle cycle
        if (input_enable && !tube_enable) begin
            saved_ctl   <= stage_ctl;
            saved_issue <= issue_type;
        end
    end

    a_reset: assert property (@(posedge clk) !rst_n |=> stage_ctl == ALL_NORMAL
        && issue_type == ISSUE_NONE && uart_disable && !ignore_pause && !pc_reset
        && !tube_enable)
    else begin
        $error("outputs differ from their reset values");
        n_reset++;
    end

    a_stall: assert property (@(posedge clk) disable iff (!rst_n)
        run_q && free && issue_type == ISSUE_NONE && dep |=> issue_type == ISSUE_DATA
        && stage_ctl.if_ctl == HAZD_CTL_RETRY && stage_ctl.id_ctl == HAZD_CTL_RETRY
        && stage_ctl.ex_ctl == HAZD_CTL_NO_OP)
    else begin
        $error("dependency did not give a data stall");
        n_stall++;
    end

    // zero indices and released dependencies land here too
    a_no_stall: assert property (@(posedge clk) disable iff (!rst_n)
        free && issue_type inside {ISSUE_NONE, ISSUE_DATA} && !dep
        |=> issue_type != ISSUE_DATA)
    else begin
        $error("data stall without a dependency");
        n_no_stall++;
    end

    a_drain: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(uart_disable) |-> $past(drain, 1) && $past(drain, 2) && $past(drain, 3)
        && $past(drain, 4) && $past(drain, 5) && $past(drain, 6)
        && issue_type == ($past(cpu_pause) ? ISSUE_PAUSE : ISSUE_FALLTHROUGH))
    else begin
        $error("drain ended early or with the wrong issue");
        n_drain++;
    end

    a_resume: assert property (@(posedge clk) disable iff (!rst_n)
        free && ((issue_type == ISSUE_PAUSE && !cpu_pause && !uart_write_enable)
        || (issue_type == ISSUE_FALLTHROUGH && !at_max))
        |=> issue_type == ISSUE_NONE && uart_disable && stage_ctl.if_ctl == HAZD_CTL_NORMAL)
    else begin
        $error("execution did not resume");
        n_resume++;
    end

    a_uart_start: assert property (@(posedge clk) disable iff (!rst_n)
        free && uart_write_enable && (issue_type == ISSUE_PAUSE
        || (issue_type == ISSUE_FALLTHROUGH && at_max)) |=> issue_type == ISSUE_UART
        && ignore_pause)
    else begin
        $error("uart session did not start");
        n_uart_start++;
    end

    a_uart_done: assert property (@(posedge clk) disable iff (!rst_n)
        free && issue_type == ISSUE_UART && uart_complete
        |=> issue_type == ISSUE_PAUSE && !ignore_pause && pc_reset)
    else begin
        $error("uart completion not handled");
        n_uart_done++;
    end

    a_pulse: assert property (@(posedge clk) disable iff (!rst_n) pc_reset |=> !pc_reset)
    else begin
        $error("pc_reset longer than one cycle");
        n_pulse++;
    end

    a_freeze: assert property (@(posedge clk) disable iff (!rst_n)
        input_enable && !tube_enable |=> tube_enable && stage_ctl == ALL_NO_OP
        && issue_type == ISSUE_KEYPAD)
    else begin
        $error("keypad request did not freeze the pipeline");
        n_freeze++;
    end

    a_restore: assert property (@(posedge clk) disable iff (!rst_n)
        tube_enable && input_complete |=> !tube_enable && stage_ctl == saved_ctl
        && issue_type == saved_issue)
    else begin
        $error("keypad exit did not restore the controls");
        n_restore++;
    end

endmodule

`default_nettype wire

//--- issue_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "hazard_settings.svh"

module issue_sequencer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   data_hazard,         // from dependency_check
    input  logic                   fallthrough,         // from dependency_check
    input  logic                   cpu_pause,           // level, user pause switch
    input  logic                   uart_write_enable,   // level, rewrite running
    input  logic                   uart_complete,       // strobe, rewrite done
    input  logic                   keypad_hold,         // freeze in progress, hold everything
    output hazard_pkg::stage_ctl_t next_ctl,            // controls for the next cycle
    output hazard_pkg::issue_t     next_issue,          // issue for the next cycle
    output logic                   uart_disable,        // 1 keeps the memories off the uart
    output logic                   ignore_pause,        // pause switch is ignored during rewrite
    output logic                   pc_reset             // one cycle, restart from address 0
);

    import hazard_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE    = 2'b00,                             // one cycle after reset for the first fetch
        ST_EXECUTE = 2'b01,
        ST_HAZARD  = 2'b10                              // stalled or drained, see issue_q
    } seq_state_t;

    seq_state_t                   state_q;
    seq_state_t                   state_d;
    logic [`STAGE_CNT_WIDTH-1:0]  gap_q;                // bubbles pushed into the pipe so far
    logic [`STAGE_CNT_WIDTH-1:0]  gap_d;
    stage_ctl_t                   ctl_q;                // copy of what the stage registers hold
    stage_ctl_t                   ctl_d;
    issue_t                       issue_q;
    issue_t                       issue_d;
    logic                         uart_disable_d;
    logic                         ignore_pause_d;
    logic                         pc_reset_d;
    logic                         drain;

    assign drain = cpu_pause | fallthrough;             // both empty the pipeline first

    always_comb begin
        state_d        = state_q;                       // hold by default
        gap_d          = gap_q;
        ctl_d          = ctl_q;
        issue_d        = issue_q;
        uart_disable_d = uart_disable;
        ignore_pause_d = ignore_pause;
        pc_reset_d     = 1'b0;                          // pulse only

        case (state_q)
            ST_EXECUTE: begin
                if (data_hazard) begin                  // stall wins, a pause can wait
                    issue_d      = ISSUE_DATA;
                    state_d      = ST_HAZARD;
                    ctl_d.if_ctl = HAZD_CTL_RETRY;      // refetch
                    ctl_d.id_ctl = HAZD_CTL_RETRY;      // redecode
                    ctl_d.ex_ctl = HAZD_CTL_NO_OP;      // bubble into ex
                end else if (drain) begin
                    ctl_d.if_ctl = HAZD_CTL_NO_OP;      // feed bubbles behind the last instruction
                    if (gap_q == `STAGE_CNT_WIDTH'(`STAGE_CNT)) begin
                        gap_d          = '0;            // pipeline is empty now
                        issue_d        = cpu_pause ? ISSUE_PAUSE : ISSUE_FALLTHROUGH;
                        state_d        = ST_HAZARD;
                        uart_disable_d = 1'b0;          // memories may take a rewrite
                    end else begin
                        gap_d = gap_q + 1'b1;
                    end
                end else begin
                    gap_d        = '0;                  // drain must be consecutive
                    ctl_d.if_ctl = HAZD_CTL_NORMAL;
                end
            end

            ST_HAZARD: begin
                case (issue_q)
                    ISSUE_DATA: begin
                        if (!data_hazard) begin
                            issue_d      = ISSUE_NONE;
                            state_d      = ST_EXECUTE;
                            ctl_d.if_ctl = HAZD_CTL_NORMAL;
                            ctl_d.id_ctl = HAZD_CTL_NORMAL;
                            ctl_d.ex_ctl = HAZD_CTL_NORMAL;
                            if (drain) begin            // drain starts right away
                                ctl_d.if_ctl = HAZD_CTL_NO_OP;
                                gap_d        = gap_q + 1'b1;
                            end else begin
                                gap_d = '0;
                            end
                        end
                    end

                    ISSUE_FALLTHROUGH: begin
                        if (!fallthrough) begin         // pc was moved, e.g. by a jump
                            issue_d        = ISSUE_NONE;
                            state_d        = ST_EXECUTE;
                            uart_disable_d = 1'b1;
                            ctl_d.if_ctl   = HAZD_CTL_NORMAL;
                        end else if (uart_write_enable) begin
                            issue_d        = ISSUE_UART;
                            ignore_pause_d = 1'b1;
                        end else if (cpu_pause) begin
                            issue_d    = ISSUE_PAUSE;
                            pc_reset_d = 1'b1;          // run again from the start after pause
                        end
                    end

                    ISSUE_PAUSE: begin
                        if (uart_write_enable) begin
                            issue_d        = ISSUE_UART;
                            ignore_pause_d = 1'b1;      // no resume halfway through a rewrite
                        end else if (!cpu_pause) begin
                            issue_d        = ISSUE_NONE;
                            state_d        = ST_EXECUTE;
                            uart_disable_d = 1'b1;
                            ctl_d.if_ctl   = HAZD_CTL_NORMAL;
                        end
                    end

                    ISSUE_UART: begin
                        if (uart_complete) begin
                            issue_d        = ISSUE_PAUSE;
                            ignore_pause_d = 1'b0;
                            pc_reset_d     = 1'b1;      // new program starts at 0
                        end
                    end

                    default: begin
                        issue_d = issue_q;
                    end
                endcase
            end

            default: begin
                state_d = ST_EXECUTE;                   // idle lasts one cycle
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q      <= ST_IDLE;
            gap_q        <= '0;
            ctl_q        <= '{default: HAZD_CTL_NORMAL};
            issue_q      <= ISSUE_NONE;
            uart_disable <= 1'b1;
            ignore_pause <= 1'b0;
        end else if (!keypad_hold) begin                // frozen while keypad entry runs
            state_q      <= state_d;
            gap_q        <= gap_d;
            ctl_q        <= ctl_d;
            issue_q      <= issue_d;
            uart_disable <= uart_disable_d;
            ignore_pause <= ignore_pause_d;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_reset <= 1'b0;
        end else begin
            pc_reset <= pc_reset_d & ~keypad_hold;      // never held, stays a single pulse
        end
    end

    assign next_ctl   = ctl_d;
    assign next_issue = issue_d;

endmodule

`default_nettype wire

//--- keypad_freeze.sv
`timescale 1ns/10ps
`default_nettype none

module keypad_freeze (
    input  logic                   clk,
    input  logic                   rst_n,
    input  hazard_pkg::stage_ctl_t next_ctl,            // from issue_sequencer
    input  hazard_pkg::issue_t     next_issue,          // from issue_sequencer
    input  logic                   input_enable,        // strobe, keypad value needed
    input  logic                   input_complete,      // strobe, user pressed enter
    output hazard_pkg::stage_ctl_t stage_ctl,           // to the stage registers
    output hazard_pkg::issue_t     issue_type,          // to the status display
    output logic                   tube_enable,         // show keypad entry on the tubes
    output logic                   keypad_hold          // to issue_sequencer
);

    import hazard_pkg::*;

    stage_ctl_t snap_ctl;                               // controls in force before the freeze
    issue_t     snap_issue;
    logic       freeze_start;

    // tube_enable doubles as the frozen flag, it is set exactly while entry runs
    assign freeze_start = input_enable & ~tube_enable;  // a second request while frozen is dropped

    // the sequencer also holds on the entering edge so it matches the snapshot
    assign keypad_hold = tube_enable | input_enable;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_ctl   <= '{default: HAZD_CTL_NORMAL};
            issue_type  <= ISSUE_NONE;
            tube_enable <= 1'b0;
        end else if (tube_enable) begin
            if (input_complete) begin                   // resume where we stopped
                stage_ctl   <= snap_ctl;
                issue_type  <= snap_issue;
                tube_enable <= 1'b0;
            end
        end else if (freeze_start) begin
            stage_ctl   <= '{default: HAZD_CTL_NO_OP};  // every stage stops
            issue_type  <= ISSUE_KEYPAD;
            tube_enable <= 1'b1;
        end else begin
            stage_ctl  <= next_ctl;                     // normal path, one cycle latency
            issue_type <= next_issue;
        end
    end

    always_ff @(posedge clk) begin
        if (freeze_start) begin
            snap_ctl   <= stage_ctl;                    // taken from the registered outputs
            snap_issue <= issue_type;
        end
    end

endmodule

`default_nettype wire

//--- tb_hazard_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "hazard_settings.svh"

module tb_hazard_unit;

    import hazard_pkg::*;

    // the tests use about 120 cycles, the wait limits bring it near 200
    localparam int CYCLE_LIMIT = 400;

    bind hazard_unit hazard_unit_asserts i_asserts (.*);

    logic                  clk;
    logic                  rst_n;
    id_regs_t              id_regs;
    stage_dest_t           ex_dest;
    stage_dest_t           mem_dest;
    logic [`ISA_WIDTH-1:0] pc;
    logic                  cpu_pause;
    logic                  uart_write_enable;
    logic                  uart_complete;
    logic                  input_enable;
    logic                  input_complete;
    stage_ctl_t            stage_ctl;
    issue_t                issue_type;
    logic                  uart_disable;
    logic                  ignore_pause;
    logic                  pc_reset;
    logic                  tube_enable;

    int         seed = 49030;
    int         cycles = 0;
    int         tests_run = 0;
    int         tests_failed = 0;
    int         tb_errors = 0;                          // errors of the running test
    int         asserts_seen = 0;                       // assertion failures already reported
    int         stall_seen;
    int         r;
    stage_ctl_t ctl_before;

    hazard_unit i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: tests still running after %0d cycles", CYCLE_LIMIT);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #10;                                            // drive point, outputs settled
    endtask

    task automatic clear_inputs();
        id_regs           = '0;
        ex_dest           = '0;
        mem_dest          = '0;
        pc                = '0;
        cpu_pause         = 1'b0;
        uart_write_enable = 1'b0;
        uart_complete     = 1'b0;
        input_enable      = 1'b0;
        input_complete    = 1'b0;
    endtask

    task automatic random_operands();
        r = $random(seed);
        id_regs.src1_idx  = {3'b000, r[1:0]};           // few registers, many matches
        id_regs.src2_idx  = {3'b000, r[3:2]};
        id_regs.dest_idx  = {3'b000, r[5:4]};
        id_regs.branch    = r[6];
        id_regs.store     = r[7];
        ex_dest.reg_write = r[8];
        ex_dest.mem_read  = r[9];
        ex_dest.dest_idx  = {3'b000, r[11:10]};
        mem_dest.reg_write = r[12];
        mem_dest.mem_read = r[13];
        mem_dest.dest_idx = {3'b000, r[15:14]};
    endtask

    task automatic wait_issue(input issue_t want, input int max_cycles);
        int n;
        n = 0;
        while (issue_type != want && n < max_cycles) begin
            step(1);
            n++;
        end
        if (issue_type != want) begin
            $display("issue_type did not reach %s within %0d cycles at %0t",
                     want.name(), max_cycles, $time);
            tb_errors++;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
            tb_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        int errs;
        step(2);                                        // last consequents get evaluated
        errs = i_dut.i_asserts.fail_cnt - asserts_seen + tb_errors;
        asserts_seen = i_dut.i_asserts.fail_cnt;
        tb_errors = 0;
        tests_run++;
        if (errs == 0) begin
            $display("test %-14s ok", name);
        end else begin
            tests_failed++;
            $display("test %-14s FAILED with %0d errors", name, errs);
        end
    endtask

    initial begin
        clear_inputs();
        rst_n = 1'b0;
        step(4);
        rst_n = 1'b1;
        check_value("stage_ctl", 32'h0, 32'(stage_ctl));
        check_value("issue_type", 32'(ISSUE_NONE), 32'(issue_type));
        check_value("uart_disable", 32'h1, 32'(uart_disable));
        check_value("ignore_pause", 32'h0, 32'(ignore_pause));
        check_value("pc_reset", 32'h0, 32'(pc_reset));
        check_value("tube_enable", 32'h0, 32'(tube_enable));
        finish_test("reset state");

        id_regs.branch    = 1'b1;                       // x0 against a writing load, no stall
        id_regs.store     = 1'b1;
        ex_dest.reg_write = 1'b1;
        ex_dest.mem_read  = 1'b1;
        step(1);
        stall_seen = 0;
        repeat (40) begin
            random_operands();
            step(1);
            if (issue_type == ISSUE_DATA)
                stall_seen++;
        end
        clear_inputs();
        wait_issue(ISSUE_NONE, 3);
        if (stall_seen == 0) begin
            $display("random operands never produced a data stall");
            tb_errors++;
        end
        finish_test("data stall");

        cpu_pause = 1'b1;
        wait_issue(ISSUE_PAUSE, 12);                    // drain takes six edges
        check_value("uart_disable", 32'h0, 32'(uart_disable));
        cpu_pause = 1'b0;
        wait_issue(ISSUE_NONE, 3);
        check_value("uart_disable", 32'h1, 32'(uart_disable));
        finish_test("pause drain");

        cpu_pause = 1'b1;
        wait_issue(ISSUE_PAUSE, 12);
        uart_write_enable = 1'b1;
        wait_issue(ISSUE_UART, 3);
        check_value("ignore_pause", 32'h1, 32'(ignore_pause));
        step(2);
        uart_write_enable = 1'b0;                       // released before the completion strobe
        uart_complete     = 1'b1;
        step(1);
        uart_complete = 1'b0;
        check_value("pc_reset", 32'h1, 32'(pc_reset));
        step(1);
        check_value("pc_reset", 32'h0, 32'(pc_reset));
        cpu_pause = 1'b0;
        wait_issue(ISSUE_NONE, 3);
        finish_test("uart session");

        pc = `PC_MAX_VALUE;
        wait_issue(ISSUE_FALLTHROUGH, 12);
        pc = '0;                                        // a jump moved the pc away
        wait_issue(ISSUE_NONE, 3);
        finish_test("fallthrough");

        id_regs.src1_idx  = 5'd3;                       // branch on the ex result keeps a stall up
        id_regs.branch    = 1'b1;
        ex_dest.reg_write = 1'b1;
        ex_dest.dest_idx  = 5'd3;
        wait_issue(ISSUE_DATA, 3);
        ctl_before.if_ctl  = HAZD_CTL_RETRY;            // stall controls in force at the freeze
        ctl_before.id_ctl  = HAZD_CTL_RETRY;
        ctl_before.ex_ctl  = HAZD_CTL_NO_OP;
        ctl_before.mem_ctl = HAZD_CTL_NORMAL;
        ctl_before.wb_ctl  = HAZD_CTL_NORMAL;
        input_enable = 1'b1;
        step(1);
        input_enable = 1'b0;
        check_value("tube_enable", 32'h1, 32'(tube_enable));
        step(3);
        input_complete = 1'b1;
        step(1);
        input_complete = 1'b0;
        check_value("stage_ctl", 32'(ctl_before), 32'(stage_ctl));
        check_value("issue_type", 32'(ISSUE_DATA), 32'(issue_type));
        check_value("tube_enable", 32'h0, 32'(tube_enable));
        clear_inputs();
        wait_issue(ISSUE_NONE, 3);
        finish_test("keypad freeze");

        $display("%0d tests, %0d passed, %0d failed, %0d assertion failures",
                 tests_run, tests_run - tests_failed, tests_failed, asserts_seen);
        if (tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
hazard_pkg.sv
dependency_check.sv
issue_sequencer.sv
keypad_freeze.sv
hazard_unit.sv
hazard_unit_asserts.sv
tb_hazard_unit.sv
